// ==== src/s16_bus_pkg.sv ====
// ******************************
// s16 bus package
// bus widths, request, regions and map fields
// ******************************
`default_nettype none

package s16_bus_pkg;

    typedef logic [23:1] cpu_addr_t;    // word address, A23..A1
    typedef logic [15:0] cpu_data_t;
    typedef logic [16:0] rom_addr_t;    // 256 kB of program
    typedef logic [13:0] mem_addr_t;    // local video and work RAM

    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t wdata;
        logic      rnw;
        logic [1:0] dsn;    // upper, lower, active low
    } bus_req_t;

    typedef enum logic [3:0] {
        region_none, region_rom, region_vram, region_char, region_obj,
        region_pal, region_io, region_wdog, region_ram
    } region_e;

    typedef struct packed {
        logic rom;
        logic vram;
        logic chr;
        logic obj;
        logic pal;
        logic io;
        logic wdog;
        logic ram;
    } cs_t;

    // A23..A22 field
    localparam logic [1:0] top_rom = 2'd0;
    localparam logic [1:0] top_obj = 2'd1;
    localparam logic [1:0] top_pal = 2'd2;
    localparam logic [1:0] top_sys = 2'd3;

    // A18..A16 field
    localparam logic [2:0] mid_vram  = 3'd0;
    localparam logic [2:0] mid_char  = 3'd1;
    localparam logic [2:0] mid_io_lo = 3'd4;
    localparam logic [2:0] mid_io_hi = 3'd5;
    localparam logic [2:0] mid_wdog  = 3'd6;
    localparam logic [2:0] mid_ram   = 3'd7;

    localparam cpu_data_t   data_ones  = 16'hffff;
    localparam int unsigned wait_limit = 64;   // slowest legal rom/ram answer

endpackage

`default_nettype wire

// ==== src/s16_cab_pkg.sv ====
// ******************************
// s16 cabinet package
// game ids and cabinet input types
// ******************************
`default_nettype none

package s16_cab_pkg;

    typedef logic [7:0] game_id_t;
    typedef logic [7:0] joy_t;

    // Passing Shot board variants
    localparam game_id_t game_passsht  = 8'h10;
    localparam game_id_t game_passsht2 = 8'h11;
    localparam game_id_t game_passsht3 = 8'h12;

    typedef struct packed {
        joy_t       joy1;
        joy_t       joy2;
        joy_t       joy3;
        joy_t       joy4;
        logic [3:0] start;
        logic [1:0] coin;
        logic       service;
        logic       dip_test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

    // io slot, picked by A13..A12
    typedef enum logic [1:0] {
        port_ppi    = 2'd0,
        port_inputs = 2'd1,
        port_dips   = 2'd2
    } port_e;

endpackage

`default_nettype wire

// ==== src/s16_addr_decode.sv ====
// ******************************
// s16 address decoder
// System 16A memory map, word address slicing
// ******************************
`default_nettype none

module s16_addr_decode (
    input  s16_bus_pkg::cpu_addr_t addr,
    output s16_bus_pkg::region_e   region,
    output s16_bus_pkg::rom_addr_t rom_addr,
    output s16_bus_pkg::mem_addr_t mem_addr
);
    import s16_bus_pkg::*;

    logic [1:0] top;    // A23..A22
    logic [2:0] mid;    // A18..A16

    assign top = addr[23:22];
    assign mid = addr[18:16];

    assign rom_addr = addr[17:1];  // 00-03
    assign mem_addr = addr[14:1];  // shared by vram and work ram

    // first hit wins, order matters for the A22 overlaps
    always_comb begin
        if (top == top_rom && !addr[18]) begin
            region = region_rom;
        end else if (addr[22] && mid == mid_vram) begin
            region = region_vram;      // 40
        end else if (addr[22] && mid == mid_char) begin
            region = region_char;      // 41
        end else if (top == top_obj && addr[18]) begin
            region = region_obj;       // 44
        end else if (top == top_pal && addr[18]) begin
            region = region_pal;       // 84
        end else if (top == top_sys && (mid == mid_io_lo || mid == mid_io_hi)) begin
            region = region_io;        // c4
        end else if (top == top_sys && mid == mid_wdog) begin
            region = region_wdog;      // c6
        end else if (top == top_sys && mid == mid_ram) begin
            region = region_ram;       // c7
        end else begin
            region = region_none;
        end
    end

endmodule

`default_nettype wire

// ==== src/s16_bus_ctrl.sv ====
// ******************************
// s16 bus cycle controller
// chip selects, memory waits, read data mux
// ******************************
`default_nettype none

module s16_bus_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  s16_bus_pkg::bus_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output s16_bus_pkg::cpu_data_t rdata,
    input  s16_bus_pkg::region_e   region,
    output s16_bus_pkg::cs_t       cs,
    output logic                   io_rd,
    input  logic [7:0]             cab_dout,
    output s16_bus_pkg::cpu_data_t wdata,
    output logic [1:0]             dswn,
    input  s16_bus_pkg::cpu_data_t rom_data,
    input  logic                   rom_ok,
    input  s16_bus_pkg::cpu_data_t ram_data,
    input  logic                   ram_ok,
    input  s16_bus_pkg::cpu_data_t char_dout,
    input  s16_bus_pkg::cpu_data_t pal_dout,
    input  s16_bus_pkg::cpu_data_t obj_dout
);
    import s16_bus_pkg::*;

    typedef enum logic [1:0] {st_idle, st_access, st_release} state_e;

    state_e    state;
    cs_t       cs_next;
    cpu_data_t slow_q;     // rom or ram word, caught with its ok
    logic      slow_cs;
    logic      slow_ok;

    assign slow_cs = cs.rom | cs.vram | cs.ram;
    assign slow_ok = (cs.rom & rom_ok) | ((cs.vram | cs.ram) & ram_ok);

    always_comb begin
        cs_next = '0;
        case (region)
            region_rom:  cs_next.rom  = 1'b1;
            region_vram: cs_next.vram = 1'b1;
            region_char: cs_next.chr  = 1'b1;
            region_obj:  cs_next.obj  = 1'b1;
            region_pal:  cs_next.pal  = 1'b1;
            region_io:   cs_next.io   = 1'b1;
            region_wdog: cs_next.wdog = 1'b1;
            region_ram:  cs_next.ram  = 1'b1;
            default:     cs_next = '0;  // unmapped, no select
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            cs        <= '0;
            io_rd     <= 1'b0;
            req_ready <= 1'b0;
            dswn      <= 2'b11;
        end else begin
            io_rd <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_access;
                        cs    <= cs_next;
                        io_rd <= region == region_io;
                        dswn  <= req.rnw ? 2'b11 : req.dsn;
                    end
                end
                st_access: begin
                    if (req_ready) begin        // handshake done
                        state     <= st_release;
                        cs        <= '0;
                        req_ready <= 1'b0;
                        dswn      <= 2'b11;
                    end else if (!slow_cs || slow_ok) begin
                        req_ready <= 1'b1;      // fast regions always land here
                    end
                end
                st_release: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) wdata <= req.wdata;
        if (slow_ok && !req_ready) slow_q <= cs.rom ? rom_data : ram_data;
    end

    // fast sources are already valid in the ready cycle
    always_comb begin
        if (slow_cs)     rdata = slow_q;
        else if (cs.chr) rdata = char_dout;
        else if (cs.obj) rdata = obj_dout;
        else if (cs.pal) rdata = pal_dout;
        else if (cs.io)  rdata = {8'hff, cab_dout};
        else             rdata = data_ones;   // wdog, ppi and holes
    end

    // decoder, cabinet port and memory address all follow req until ready
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> $stable(req));

    // a memory that never answers would hang the master
    a_cs_bounded: assert property (@(posedge clk) disable iff (rst)
        $rose(|cs) |-> ##[1:wait_limit] !(|cs));

endmodule

`default_nettype wire

// ==== src/s16_cab_io.sv ====
// ******************************
// s16 cabinet inputs
// io ports, dips, four player counter
// ******************************
`default_nettype none

module s16_cab_io (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   io_rd,
    input  s16_bus_pkg::cpu_addr_t addr,
    input  s16_cab_pkg::game_id_t  game_id,
    input  s16_cab_pkg::cab_in_t   cab,
    output logic [7:0]             cab_dout
);
    import s16_cab_pkg::*;

    port_e      slot;
    logic       pass_sht;
    logic [1:0] port_cnt;   // which Passing Shot player comes next
    joy_t       pass_sel;
    logic [7:0] dout_next;
    logic       cnt_clr;
    logic       cnt_inc;

    function automatic joy_t sort_joy(input joy_t j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    function automatic joy_t pass_joy(input joy_t j);
        return {j[7:4], j[1:0], j[3:2]};
    endfunction

    assign slot     = port_e'(addr[13:12]);
    assign pass_sht = game_id == game_passsht || game_id == game_passsht2 ||
                      game_id == game_passsht3;

    always_comb begin
        case (port_cnt)
            2'd0:    pass_sel = cab.joy1;
            2'd1:    pass_sel = cab.joy2;
            2'd2:    pass_sel = cab.joy3;
            default: pass_sel = cab.joy4;
        endcase
    end

    always_comb begin
        dout_next = 8'hff;
        cnt_clr   = 1'b0;
        cnt_inc   = 1'b0;
        case (slot)
            port_ppi: dout_next = 8'hff;     // 8255 no longer fitted
            port_inputs: begin
                case (addr[2:1])
                    2'd0: begin
                        dout_next = {pass_sht ? cab.start[3:2] : 2'b11, cab.start[1:0],
                                     cab.service, cab.dip_test, cab.coin};
                        cnt_clr   = pass_sht;
                    end
                    2'd1: begin
                        dout_next = pass_sht ? pass_joy(pass_sel) : sort_joy(cab.joy1);
                        cnt_inc   = pass_sht;
                    end
                    2'd3:    dout_next = sort_joy(cab.joy2);
                    default: dout_next = 8'hff;  // port 2
                endcase
            end
            port_dips: dout_next = addr[1] ? cab.dipsw_b : cab.dipsw_a;
            default:   dout_next = 8'hff;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            port_cnt <= 2'd0;
        end else if (io_rd) begin
            if (cnt_clr) begin
                port_cnt <= 2'd0;
            end else if (cnt_inc) begin
                port_cnt <= port_cnt + 2'd1;   // wraps back to player 1
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_rd) cab_dout <= dout_next;
    end

endmodule

`default_nettype wire

// ==== src/s16_vint_irq.sv ====
// ******************************
// s16 vblank interrupt
// edge detect and latch with ack
// ******************************
`default_nettype none

module s16_vint_irq (
    input  logic clk,
    input  logic rst,
    input  logic vint,
    input  logic iack,
    output logic irq_n
);
    logic vint_s;     // sampled vint
    logic vint_q;     // previous sample
    logic vint_edge;

    assign vint_edge = vint_s & ~vint_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vint_s <= 1'b0;
            vint_q <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            vint_s <= vint;
            vint_q <= vint_s;
            if (iack) begin
                irq_n <= 1'b1;   // ack beats a fresh edge
            end else if (vint_edge) begin
                irq_n <= 1'b0;
            end
        end
    end

    // irq only follows a vint rise two cycles back
    a_irq_after_edge: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> $past(vint, 2) && !$past(vint, 3));

endmodule

`default_nettype wire

// ==== src/s16_main.sv ====
// ******************************
// s16 main bus glue
// controller, map, cabinet and vblank irq
// ******************************
`default_nettype none

module s16_main (
    input  logic                   clk,
    input  logic                   rst,
    // master side
    input  s16_bus_pkg::bus_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output s16_bus_pkg::cpu_data_t rdata,
    // memories
    output s16_bus_pkg::cs_t       cs,
    output s16_bus_pkg::rom_addr_t rom_addr,
    output s16_bus_pkg::mem_addr_t mem_addr,
    output s16_bus_pkg::cpu_data_t wdata,
    output logic [1:0]             dswn,
    input  s16_bus_pkg::cpu_data_t rom_data,
    input  logic                   rom_ok,
    input  s16_bus_pkg::cpu_data_t ram_data,   // vram or work ram
    input  logic                   ram_ok,
    input  s16_bus_pkg::cpu_data_t char_dout,
    input  s16_bus_pkg::cpu_data_t pal_dout,
    input  s16_bus_pkg::cpu_data_t obj_dout,
    // cabinet
    input  s16_cab_pkg::game_id_t  game_id,
    input  s16_cab_pkg::cab_in_t   cab,
    // video
    input  logic                   vint,
    input  logic                   iack,
    output logic                   irq_n
);
    import s16_bus_pkg::*;

    region_e    region;
    logic       io_rd;
    logic [7:0] cab_dout;

    s16_addr_decode u_decode (
        .addr     ( req.addr  ),
        .region   ( region    ),
        .rom_addr ( rom_addr  ),
        .mem_addr ( mem_addr  )
    );

    s16_bus_ctrl u_ctrl (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .req       ( req       ),
        .req_valid ( req_valid ),
        .req_ready ( req_ready ),
        .rdata     ( rdata     ),
        .region    ( region    ),
        .cs        ( cs        ),
        .io_rd     ( io_rd     ),
        .cab_dout  ( cab_dout  ),
        .wdata     ( wdata     ),
        .dswn      ( dswn      ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .ram_data  ( ram_data  ),
        .ram_ok    ( ram_ok    ),
        .char_dout ( char_dout ),
        .pal_dout  ( pal_dout  ),
        .obj_dout  ( obj_dout  )
    );

    s16_cab_io u_cab (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .io_rd    ( io_rd     ),
        .addr     ( req.addr  ),   // held stable through the cycle
        .game_id  ( game_id   ),
        .cab      ( cab       ),
        .cab_dout ( cab_dout  )
    );

    s16_vint_irq u_irq (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .vint  ( vint  ),
        .iack  ( iack  ),
        .irq_n ( irq_n )
    );

endmodule

`default_nettype wire

// ==== verif/s16_main_ref.svh ====
// ******************************
// s16 main reference model
// expected regions, memory words, cabinet bytes
// ******************************
`ifndef S16_MAIN_REF_SVH
`define S16_MAIN_REF_SVH

function automatic region_e exp_region(input cpu_addr_t a);
    logic [1:0] t;
    logic [2:0] m;
    t = a[23:22];
    m = a[18:16];
    if (t == 2'd0 && a[18] == 1'b0)                  return region_rom;
    if (a[22] && m == 3'd0)                          return region_vram;
    if (a[22] && m == 3'd1)                          return region_char;
    if (t == 2'd1 && a[18])                          return region_obj;
    if (t == 2'd2 && a[18])                          return region_pal;
    if (t == 2'd3 && (m == 3'd4 || m == 3'd5))       return region_io;
    if (t == 2'd3 && m == 3'd6)                      return region_wdog;
    if (t == 2'd3 && m == 3'd7)                      return region_ram;
    return region_none;
endfunction

function automatic cs_t exp_cs(input region_e r);
    cs_t c;
    c = '0;
    c.rom  = (r == region_rom);
    c.vram = (r == region_vram);
    c.chr  = (r == region_char);
    c.obj  = (r == region_obj);
    c.pal  = (r == region_pal);
    c.io   = (r == region_io);
    c.wdog = (r == region_wdog);
    c.ram  = (r == region_ram);
    return c;
endfunction

function automatic logic is_slow(input region_e r);
    return r == region_rom || r == region_vram || r == region_ram;
endfunction

// fake memory contents, known to the memories and the checker alike
function automatic cpu_data_t rom_word(input rom_addr_t a);
    return a[15:0] ^ {a[16], 15'h1234};
endfunction

function automatic cpu_data_t ram_word(input logic vram, input mem_addr_t a);
    return {vram, 1'b0, a} ^ 16'hc3a5;
endfunction

function automatic cpu_data_t fast_word(input region_e r, input mem_addr_t a);
    case (r)
        region_char: return {2'b01, a};
        region_obj:  return {2'b10, a};
        default:     return {2'b11, a} ^ 16'h5a5a;   // palette
    endcase
endfunction

function automatic joy_t std_joy(input joy_t j);
    return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
endfunction

function automatic joy_t four_joy(input joy_t j);
    return {j[7], j[6], j[5], j[4], j[1], j[0], j[3], j[2]};
endfunction

// standard cabinet only, no player counter
function automatic logic [7:0] cab_byte(input cpu_addr_t a, input cab_in_t c);
    if (a[13:12] == 2'd2) return a[1] ? c.dipsw_b : c.dipsw_a;
    if (a[13:12] != 2'd1) return 8'hff;
    case (a[2:1])
        2'd0:    return {2'b11, c.start[1:0], c.service, c.dip_test, c.coin};
        2'd1:    return std_joy(c.joy1);
        2'd3:    return std_joy(c.joy2);
        default: return 8'hff;
    endcase
endfunction

function automatic cpu_data_t exp_read(input cpu_addr_t a, input cab_in_t c);
    region_e r;
    r = exp_region(a);
    case (r)
        region_rom:  return rom_word(a[17:1]);
        region_vram: return ram_word(1'b1, a[14:1]);
        region_ram:  return ram_word(1'b0, a[14:1]);
        region_char, region_obj, region_pal: return fast_word(r, a[14:1]);
        region_io:   return {8'hff, cab_byte(a, c)};
        default:     return 16'hffff;
    endcase
endfunction

`endif

// ==== verif/s16_main_tb.sv ====
// ******************************
// s16 main testbench
// random and directed bus cycles, irq checks
// ******************************
`default_nettype none

module s16_main_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import s16_bus_pkg::*;
    import s16_cab_pkg::*;
    `include "s16_main_ref.svh"

    typedef struct packed {
        cs_t        cs;
        logic       rd;
        cpu_data_t  data;
        cpu_data_t  wdata;
        logic [1:0] dswn;
        logic       chk_maddr;
        mem_addr_t  maddr;
    } exp_t;

    localparam int wait_max = 2 * wait_limit;

    logic clk;
    logic rst;
    bus_req_t req;
    logic req_valid, req_ready;
    cpu_data_t rdata, wdata, rom_data, ram_data, char_dout, pal_dout, obj_dout;
    cs_t cs;
    rom_addr_t rom_addr;
    mem_addr_t mem_addr;
    logic [1:0] dswn;
    logic rom_ok, ram_ok;
    game_id_t game_id;
    cab_in_t cab;
    logic vint, iack, irq_n;

    logic [16:0] stim_lfsr = 17'd76536;
    logic [16:0] mem_lfsr  = 17'd76536;
    logic [2:0] rom_cnt, ram_cnt, mem_delay;
    exp_t exp_q[$];
    exp_t got;
    int errors = 0;
    int checks = 0;

    s16_main uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};    // x^17 + x^14 + 1
    endfunction

    function logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[62:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function logic [2:0] pick_delay();
        logic [2:0] v;
        v = '0;
        for (int i = 0; i < 3; i++) begin
            mem_lfsr = lfsr_next(mem_lfsr);
            v = {v[1:0], mem_lfsr[0]};
        end
        return v;
    endfunction

    function automatic cpu_addr_t io_addr(input logic [1:0] slot, input logic [1:0] port);
        cpu_addr_t a;
        a = '0;
        a[23:22] = 2'b11;
        a[18:16] = 3'd4;
        a[13:12] = slot;
        a[2:1]   = port;
        return a;
    endfunction

    // one delay draw per cycle for both memories
    always @(posedge clk) begin
        mem_delay <= pick_delay();
    end

    // slow memories, ok after 0..7 cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok <= 1'b0;
            rom_data <= '0;
            rom_cnt <= '0;
        end else if (cs.rom) begin
            if (rom_cnt == 0) begin
                rom_ok <= 1'b1;
                rom_data <= rom_word(rom_addr);
            end else begin
                rom_cnt <= rom_cnt - 3'd1;
            end
        end else begin
            rom_ok <= 1'b0;
            rom_cnt <= mem_delay;
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_ok <= 1'b0;
            ram_data <= '0;
            ram_cnt <= '0;
        end else if (cs.vram || cs.ram) begin
            if (ram_cnt == 0) begin
                ram_ok <= 1'b1;
                ram_data <= ram_word(cs.vram, mem_addr);
            end else begin
                ram_cnt <= ram_cnt - 3'd1;
            end
        end else begin
            ram_ok <= 1'b0;
            ram_cnt <= mem_delay;
        end
    end

    // video chips answer one cycle later
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            char_dout <= '0;
            obj_dout <= '0;
            pal_dout <= '0;
        end else begin
            char_dout <= fast_word(region_char, mem_addr);
            obj_dout <= fast_word(region_obj, mem_addr);
            pal_dout <= fast_word(region_pal, mem_addr);
        end
    end

    // compare each completed cycle with its expectation
    always @(negedge clk) begin
        if (!rst && req_valid && req_ready) begin
            if (exp_q.size() == 0) begin
                $display("a cycle completed with nothing expected at %0t", $time);
                errors++;
            end else begin
                got = exp_q.pop_front();
                checks++;
                if (cs != got.cs) begin
                    $display("error %0t: cs %b expected %b", $time, cs, got.cs);
                    errors++;
                end
                if (got.rd && rdata != got.data) begin
                    $display("error %0t: rdata %h expected %h", $time, rdata, got.data);
                    errors++;
                end
                if (dswn != got.dswn) begin
                    $display("error %0t: dswn %b expected %b", $time, dswn, got.dswn);
                    errors++;
                end
                if (!got.rd && wdata != got.wdata) begin
                    $display("error %0t: wdata %h expected %h", $time, wdata, got.wdata);
                    errors++;
                end
                if (got.chk_maddr && mem_addr != got.maddr) begin
                    $display("error %0t: mem_addr %h expected %h", $time, mem_addr, got.maddr);
                    errors++;
                end
            end
        end
    end

    task automatic run_cycle(input bus_req_t r, input exp_t e);
        int n;
        logic fast;
        fast = !is_slow(exp_region(r.addr));
        @(posedge clk);
        req <= r;
        req_valid <= 1'b1;
        exp_q.push_back(e);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!req_ready && n < wait_max);
        if (!req_ready) begin
            $display("bus cycle to %h never completed", r.addr);
            errors++;
            exp_q.delete();
        end else if (fast && n != 3) begin
            $display("error %0t: fast cycle took %0d cycles, expected 3", $time, n);
            errors++;
        end
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        if (cs != '0) begin  // release cycle
            $display("error %0t: cs %b during release", $time, cs);
            errors++;
        end
    endtask

    task automatic read_expect(input cpu_addr_t a, input cpu_data_t d);
        bus_req_t r;
        exp_t e;
        r = '{addr: a, wdata: cpu_data_t'(rand_bits(16)), rnw: 1'b1, dsn: 2'b00};
        e = '{cs: exp_cs(exp_region(a)), rd: 1'b1, data: d, wdata: '0, dswn: 2'b11,
              chk_maddr: 1'b0, maddr: '0};
        run_cycle(r, e);
    endtask

    task automatic write_at(input cpu_addr_t a);
        bus_req_t r;
        exp_t e;
        r = '{addr: a, wdata: cpu_data_t'(rand_bits(16)), rnw: 1'b0,
              dsn: 2'(rand_bits(2))};
        e = '{cs: exp_cs(exp_region(a)), rd: 1'b0, data: '0, wdata: r.wdata, dswn: r.dsn,
              chk_maddr: 1'b1, maddr: a[14:1]};
        run_cycle(r, e);
    endtask

    task automatic check_irq();
        int n;
        @(posedge clk);
        vint <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (irq_n && n < wait_max);
        checks++;
        if (irq_n) begin
            $display("irq_n never fell after vint rose");
            errors++;
        end else if (n != 3) begin
            $display("error %0t: irq_n fell at negedge %0d, expected 3", $time, n);
            errors++;
        end
        @(posedge clk);
        iack <= 1'b1;
        @(posedge clk);
        iack <= 1'b0;
        @(negedge clk);
        if (!irq_n) begin
            $display("error %0t: irq_n still low after iack", $time);
            errors++;
        end
        for (n = 0; n < 6; n++) begin
            @(negedge clk);
            if (!irq_n) begin
                $display("error %0t: held vint retriggered irq", $time);
                errors++;
            end
        end
        @(posedge clk);
        vint <= 1'b0;
    endtask

    initial begin
        logic [63:0] bits;
        cpu_addr_t a;
        cpu_data_t d;
        rst <= 1'b1;
        req <= '0;
        req_valid <= 1'b0;
        game_id <= '0;
        cab <= '0;
        vint <= 1'b0;
        iack <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        bits = rand_bits(56);
        cab <= cab_in_t'(bits[55:0]);
        @(posedge clk);

        for (int i = 0; i < 120; i++) begin
            a = cpu_addr_t'(rand_bits(23));
            read_expect(a, exp_read(a, cab));
        end
        read_expect(io_addr(2'd0, 2'd0), 16'hffff);   // former ppi
        read_expect({2'b11, 3'd0, 3'd6, 15'd0}, 16'hffff);   // watchdog
        for (int p = 0; p < 4; p++) begin
            read_expect(io_addr(2'd1, 2'(p)), exp_read(io_addr(2'd1, 2'(p)), cab));
        end
        read_expect(io_addr(2'd2, 2'd0), {8'hff, cab.dipsw_a});
        read_expect(io_addr(2'd2, 2'd1), {8'hff, cab.dipsw_b});

        for (int i = 0; i < 8; i++) begin
            write_at({2'b01, 3'(rand_bits(3)), 3'd1, 15'(rand_bits(15))});  // char
            write_at({2'b10, 3'(rand_bits(3)), 3'd4, 15'(rand_bits(15))});  // pal
            write_at({2'b11, 3'(rand_bits(3)), 3'd7, 15'(rand_bits(15))});  // ram
        end

        @(posedge clk);
        game_id <= game_passsht2;
        @(posedge clk);
        read_expect(io_addr(2'd1, 2'd0), {8'hff, cab.start[3:2], cab.start[1:0],
                                          cab.service, cab.dip_test, cab.coin});
        read_expect(io_addr(2'd1, 2'd1), {8'hff, four_joy(cab.joy1)});
        read_expect(io_addr(2'd1, 2'd1), {8'hff, four_joy(cab.joy2)});
        read_expect(io_addr(2'd1, 2'd1), {8'hff, four_joy(cab.joy3)});
        read_expect(io_addr(2'd1, 2'd1), {8'hff, four_joy(cab.joy4)});
        d = {8'hff, four_joy(cab.joy1)};   // counter wrapped
        read_expect(io_addr(2'd1, 2'd1), d);
        // counter now points at player 2, port 0 brings it back
        read_expect(io_addr(2'd1, 2'd0), {8'hff, cab.start[3:2], cab.start[1:0],
                                          cab.service, cab.dip_test, cab.coin});
        read_expect(io_addr(2'd1, 2'd1), d);

        check_irq();
        check_irq();

        if (exp_q.size() != 0) begin
            $display("%0d expected cycles were never completed", exp_q.size());
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (60000) @(posedge clk);
        $display("run did not reach its end before the watchdog limit");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== s16_main.f ====
src/s16_bus_pkg.sv
src/s16_cab_pkg.sv
src/s16_addr_decode.sv
src/s16_bus_ctrl.sv
src/s16_cab_io.sv
src/s16_vint_irq.sv
src/s16_main.sv
+incdir+verif
verif/s16_main_tb.sv

// ==== Makefile ====
# Verilator build and run for the s16 main bus glue

.PHONY: all lint clean

all: obj_dir/Vs16_main_tb
	@out=$$(./obj_dir/Vs16_main_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

obj_dir/Vs16_main_tb: s16_main.f src/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -j 0 \
		--top-module s16_main_tb -f s16_main.f

lint:
	verilator --lint-only -Wall --top-module s16_main \
		src/s16_bus_pkg.sv src/s16_cab_pkg.sv src/s16_addr_decode.sv \
		src/s16_bus_ctrl.sv src/s16_cab_io.sv src/s16_vint_irq.sv \
		src/s16_main.sv

clean:
	rm -rf obj_dir
